// ==== logic/rv_pkg.sv ====
package rv_pkg;

    // major opcodes handled by the pipeline
    localparam logic [6:0] OP_LUI    = 7'b0110111;
    localparam logic [6:0] OP_AUIPC  = 7'b0010111;
    localparam logic [6:0] OP_JAL    = 7'b1101111;
    localparam logic [6:0] OP_JALR   = 7'b1100111;
    localparam logic [6:0] OP_BRANCH = 7'b1100011;
    localparam logic [6:0] OP_IMM    = 7'b0010011;
    localparam logic [6:0] OP_REG    = 7'b0110011;

    typedef enum logic [3:0] {
        ALU_ADD, ALU_SUB, ALU_SLL, ALU_SLT, ALU_SLTU, ALU_XOR,
        ALU_SRL, ALU_SRA, ALU_OR, ALU_AND, ALU_PASS_OP2
    } alu_ctrl_t;

    typedef enum logic [2:0] {
        BR_NONE, BR_BEQ, BR_BNE, BR_BLT, BR_BGE, BR_BLTU, BR_BGEU
    } br_func_t;

    typedef enum logic [1:0] {
        PC_INC, PC_BR, PC_JAL
    } pc_source_t;

    // operand source picked in decode
    typedef enum logic [1:0] {
        FWD_M  = 2'b00,
        FWD_W  = 2'b01,
        FWD_RF = 2'b10
    } fwd_sel_t;

    typedef struct packed {
        logic       alu_imm;
        logic       alu_pc;
        logic       jal_base_pc;
        logic       writes_rd;
        alu_ctrl_t  alu_ctrl;
        br_func_t   br_func;
        pc_source_t pc_source;
    } ex_ctrl_t;

endpackage

// ==== logic/pipe_if.sv ====
`timescale 1ns/1ns

interface dec_ex_if;
    logic             valid;
    rv_pkg::ex_ctrl_t ctrl;
    logic [4:0]       rd;
    logic [31:0]      rs1_data;
    logic [31:0]      rs2_data;
    logic [31:0]      imm;
    logic [31:0]      pc;
    rv_pkg::fwd_sel_t fwd_rs1;
    rv_pkg::fwd_sel_t fwd_rs2;

    modport dec (output valid, ctrl, rd, rs1_data, rs2_data, imm, pc, fwd_rs1, fwd_rs2);
    modport ex (input valid, ctrl, rd, rs1_data, rs2_data, imm, pc, fwd_rs1, fwd_rs2);
endinterface

interface fwd_if;
    // one ahead of execute
    logic        m_valid;
    logic [4:0]  m_rd;
    logic [31:0] m_data;
    // two ahead, already in the register file
    logic        w_valid;
    logic [4:0]  w_rd;
    logic [31:0] w_data;

    modport wb (output m_valid, m_rd, m_data, w_valid, w_rd, w_data);
    modport dec (input m_valid, m_rd, m_data, w_valid, w_rd);
    modport ex (input m_data, w_data);
endinterface

// ==== logic/reg_file.sv ====
`timescale 1ns/1ns

module reg_file #(
    parameter int num_regs = 32
) (
    input  logic        clk,
    input  logic        reset,
    input  logic [4:0]  rs1_addr,
    input  logic [4:0]  rs2_addr,
    output logic [31:0] rs1_data,
    output logic [31:0] rs2_data,
    input  logic        we,
    input  logic [4:0]  wd_addr,
    input  logic [31:0] wd_data
);

    logic [31:0] regs [num_regs];

    always_ff @(posedge clk) begin
        if (reset) begin
            for (int i = 0; i < num_regs; i++) begin
                regs[i] <= 32'd0;
            end
        end else if (we && wd_addr != 5'd0 && 32'(wd_addr) < num_regs) begin
            regs[wd_addr] <= wd_data;
        end
    end

    // x0 and out of range read zero
    assign rs1_data = (rs1_addr != 5'd0 && 32'(rs1_addr) < num_regs) ? regs[rs1_addr] : 32'd0;
    assign rs2_data = (rs2_addr != 5'd0 && 32'(rs2_addr) < num_regs) ? regs[rs2_addr] : 32'd0;

endmodule

// ==== logic/decode_stage.sv ====
`timescale 1ns/1ns

module decode_stage #(
    parameter int num_regs = 32
) (
    input  logic        clk,
    input  logic        reset,
    input  logic        in_valid,
    input  logic [31:0] in_instr,
    input  logic [31:0] in_pc,
    input  logic        take_branch,
    fwd_if.dec          fwd,
    dec_ex_if.dec       de
);

    logic [6:0]        opcode;
    logic [4:0]        rd;
    logic [2:0]        funct3;
    logic [4:0]        rs1;
    logic [4:0]        rs2;
    logic [6:0]        funct7;
    logic [31:0]       imm_i, imm_s, imm_b, imm_u, imm_j;
    logic [31:0]       imm;
    logic [31:0]       rf_rs1_data, rf_rs2_data;
    rv_pkg::alu_ctrl_t arith_op;
    rv_pkg::ex_ctrl_t  ctrl;
    rv_pkg::fwd_sel_t  fwd_rs1, fwd_rs2;

    // matched against the instruction in execute, then the one in writeback
    function automatic rv_pkg::fwd_sel_t pick_src(input logic [4:0] rs);
        logic live;
        live = (rs != 5'd0) && (32'(rs) < num_regs);
        if (live && de.valid && de.ctrl.writes_rd && de.rd == rs) begin
            return rv_pkg::FWD_M;
        end else if (live && fwd.m_valid && fwd.m_rd == rs) begin
            return rv_pkg::FWD_W;
        end
        return rv_pkg::FWD_RF;
    endfunction

    assign opcode = in_instr[6:0];
    assign rd     = in_instr[11:7];
    assign funct3 = in_instr[14:12];
    assign rs1    = in_instr[19:15];
    assign rs2    = in_instr[24:20];
    assign funct7 = in_instr[31:25];

    assign imm_i = {{20{in_instr[31]}}, in_instr[31:20]};
    assign imm_s = {{20{in_instr[31]}}, in_instr[31:25], in_instr[11:7]};
    assign imm_b = {{19{in_instr[31]}}, in_instr[31], in_instr[7], in_instr[30:25],
                    in_instr[11:8], 1'b0};
    assign imm_u = {in_instr[31:12], 12'd0};
    assign imm_j = {{11{in_instr[31]}}, in_instr[31], in_instr[19:12], in_instr[20],
                    in_instr[30:21], 1'b0};

    reg_file #(
        .num_regs (num_regs)
    ) u_reg_file (
        .clk      (clk),
        .reset    (reset),
        .rs1_addr (rs1),
        .rs2_addr (rs2),
        .rs1_data (rf_rs1_data),
        .rs2_data (rf_rs2_data),
        .we       (fwd.m_valid),
        .wd_addr  (fwd.m_rd),
        .wd_data  (fwd.m_data)
    );

    // funct3 to ALU op, sub only in register form
    always_comb begin
        unique case (funct3)
            3'b000:  arith_op = (opcode == rv_pkg::OP_REG && funct7[5]) ? rv_pkg::ALU_SUB
                                                                        : rv_pkg::ALU_ADD;
            3'b001:  arith_op = rv_pkg::ALU_SLL;
            3'b010:  arith_op = rv_pkg::ALU_SLT;
            3'b011:  arith_op = rv_pkg::ALU_SLTU;
            3'b100:  arith_op = rv_pkg::ALU_XOR;
            3'b101:  arith_op = funct7[5] ? rv_pkg::ALU_SRA : rv_pkg::ALU_SRL;
            3'b110:  arith_op = rv_pkg::ALU_OR;
            default: arith_op = rv_pkg::ALU_AND;
        endcase
    end

    always_comb begin
        ctrl.alu_imm     = 1'b0;
        ctrl.alu_pc      = 1'b0;
        ctrl.jal_base_pc = 1'b0;
        ctrl.writes_rd   = 1'b0;
        ctrl.alu_ctrl    = rv_pkg::ALU_ADD;
        ctrl.br_func     = rv_pkg::BR_NONE;
        ctrl.pc_source   = rv_pkg::PC_INC;
        imm              = imm_i;
        unique case (opcode)
            rv_pkg::OP_LUI: begin
                ctrl.writes_rd = 1'b1;
                ctrl.alu_imm   = 1'b1;
                ctrl.alu_ctrl  = rv_pkg::ALU_PASS_OP2;
                imm            = imm_u;
            end
            rv_pkg::OP_AUIPC: begin
                ctrl.writes_rd = 1'b1;
                ctrl.alu_imm   = 1'b1;
                ctrl.alu_pc    = 1'b1;
                imm            = imm_u;
            end
            rv_pkg::OP_JAL: begin
                ctrl.writes_rd   = 1'b1;
                ctrl.jal_base_pc = 1'b1;
                ctrl.pc_source   = rv_pkg::PC_JAL;
                imm              = imm_j;
            end
            rv_pkg::OP_JALR: begin
                ctrl.writes_rd = 1'b1;
                ctrl.pc_source = rv_pkg::PC_JAL;
            end
            rv_pkg::OP_BRANCH: begin
                ctrl.pc_source = rv_pkg::PC_BR;
                imm            = imm_b;
                unique case (funct3)
                    3'b000:  ctrl.br_func = rv_pkg::BR_BEQ;
                    3'b001:  ctrl.br_func = rv_pkg::BR_BNE;
                    3'b100:  ctrl.br_func = rv_pkg::BR_BLT;
                    3'b101:  ctrl.br_func = rv_pkg::BR_BGE;
                    3'b110:  ctrl.br_func = rv_pkg::BR_BLTU;
                    3'b111:  ctrl.br_func = rv_pkg::BR_BGEU;
                    default: ctrl.br_func = rv_pkg::BR_NONE;
                endcase
            end
            rv_pkg::OP_IMM: begin
                ctrl.writes_rd = 1'b1;
                ctrl.alu_imm   = 1'b1;
                ctrl.alu_ctrl  = arith_op;
            end
            rv_pkg::OP_REG: begin
                ctrl.writes_rd = 1'b1;
                ctrl.alu_ctrl  = arith_op;
            end
            // no-op; S form kept for stores
            default: imm = imm_s;
        endcase
    end

    always_comb begin
        fwd_rs1 = pick_src(rs1);
        fwd_rs2 = pick_src(rs2);
    end

    // squash the slot behind a redirect
    always_ff @(posedge clk) begin
        if (reset) begin
            de.valid <= 1'b0;
        end else begin
            de.valid <= in_valid && !take_branch;
        end
    end

    always_ff @(posedge clk) begin
        de.ctrl     <= ctrl;
        de.rd       <= rd;
        de.rs1_data <= rf_rs1_data;
        de.rs2_data <= rf_rs2_data;
        de.imm      <= imm;
        de.pc       <= in_pc;
        de.fwd_rs1  <= fwd_rs1;
        de.fwd_rs2  <= fwd_rs2;
    end

    a_shift_funct7: assert property (@(posedge clk) disable iff (reset)
        (in_valid && opcode == rv_pkg::OP_REG && funct3[1:0] == 2'b01)
        |-> (funct7 == 7'h00 || funct7 == 7'h20));

endmodule

// ==== logic/alu.sv ====
`timescale 1ns/1ns

module alu (
    input  logic [31:0]       alu_op1,
    input  logic [31:0]       alu_op2,
    input  rv_pkg::alu_ctrl_t alu_ctrl,
    output logic [31:0]       alu_result
);

    logic [4:0] shamt;

    assign shamt = alu_op2[4:0];

    always_comb begin
        unique case (alu_ctrl)
            rv_pkg::ALU_ADD:      alu_result = alu_op1 + alu_op2;
            rv_pkg::ALU_SUB:      alu_result = alu_op1 - alu_op2;
            rv_pkg::ALU_SLL:      alu_result = alu_op1 << shamt;
            rv_pkg::ALU_SLT:      alu_result = {31'd0, $signed(alu_op1) < $signed(alu_op2)};
            rv_pkg::ALU_SLTU:     alu_result = {31'd0, alu_op1 < alu_op2};
            rv_pkg::ALU_XOR:      alu_result = alu_op1 ^ alu_op2;
            rv_pkg::ALU_SRL:      alu_result = alu_op1 >> shamt;
            rv_pkg::ALU_SRA:      alu_result = $unsigned($signed(alu_op1) >>> shamt);
            rv_pkg::ALU_OR:       alu_result = alu_op1 | alu_op2;
            rv_pkg::ALU_AND:      alu_result = alu_op1 & alu_op2;
            // lui
            rv_pkg::ALU_PASS_OP2: alu_result = alu_op2;
            default:              alu_result = 32'd0;
        endcase
    end

endmodule

// ==== logic/execute.sv ====
`timescale 1ns/1ns

module execute (
    input  logic        clk,
    dec_ex_if.ex        de,
    fwd_if.ex           fwd,
    output logic        res_valid,
    output logic [4:0]  res_rd,
    output logic [31:0] res_data,
    output logic        take_branch,
    output logic [31:0] branch_target
);

    logic [31:0] rs1_data, rs2_data;
    logic [31:0] alu_op1, alu_op2, alu_result;
    logic [31:0] br_addr, jal_sum, jal_addr, pc_inc;
    logic        br_taken;
    logic        redirect;

    always_comb begin
        unique case (de.fwd_rs1)
            rv_pkg::FWD_M: rs1_data = fwd.m_data;
            rv_pkg::FWD_W: rs1_data = fwd.w_data;
            default:       rs1_data = de.rs1_data;
        endcase
    end

    always_comb begin
        unique case (de.fwd_rs2)
            rv_pkg::FWD_M: rs2_data = fwd.m_data;
            rv_pkg::FWD_W: rs2_data = fwd.w_data;
            default:       rs2_data = de.rs2_data;
        endcase
    end

    assign alu_op1 = de.ctrl.alu_pc ? de.pc : rs1_data;
    assign alu_op2 = de.ctrl.alu_imm ? de.imm : rs2_data;

    alu u_alu (
        .alu_op1    (alu_op1),
        .alu_op2    (alu_op2),
        .alu_ctrl   (de.ctrl.alu_ctrl),
        .alu_result (alu_result)
    );

    always_comb begin
        unique case (de.ctrl.br_func)
            rv_pkg::BR_BEQ:  br_taken = (rs1_data == rs2_data);
            rv_pkg::BR_BNE:  br_taken = (rs1_data != rs2_data);
            rv_pkg::BR_BLT:  br_taken = ($signed(rs1_data) < $signed(rs2_data));
            rv_pkg::BR_BGE:  br_taken = ($signed(rs1_data) >= $signed(rs2_data));
            rv_pkg::BR_BLTU: br_taken = (rs1_data < rs2_data);
            rv_pkg::BR_BGEU: br_taken = (rs1_data >= rs2_data);
            default:         br_taken = 1'b0;
        endcase
    end

    assign br_addr  = de.pc + de.imm;
    assign jal_sum  = (de.ctrl.jal_base_pc ? de.pc : rs1_data) + de.imm;
    // jalr drops bit 0
    assign jal_addr = {jal_sum[31:1], 1'b0};
    assign pc_inc   = de.pc + 32'd4;

    always_comb begin
        unique case (de.ctrl.pc_source)
            rv_pkg::PC_BR: begin
                redirect      = br_taken;
                branch_target = br_addr;
            end
            rv_pkg::PC_JAL: begin
                redirect      = 1'b1;
                branch_target = jal_addr;
            end
            default: begin
                redirect      = 1'b0;
                branch_target = br_addr;
            end
        endcase
    end

    assign take_branch = de.valid && redirect;

    assign res_valid = de.valid && de.ctrl.writes_rd && (de.rd != 5'd0);
    assign res_rd    = de.rd;
    assign res_data  = (de.ctrl.pc_source == rv_pkg::PC_JAL) ? pc_inc : alu_result;

    a_fwd_sel_legal: assert property (@(posedge clk)
        de.valid |-> (de.fwd_rs1 != 2'b11 && de.fwd_rs2 != 2'b11));

    // slot behind a redirect arrives squashed
    a_no_back_to_back_redirect: assert property (@(posedge clk)
        take_branch |=> !take_branch);

endmodule

// ==== logic/writeback_stage.sv ====
`timescale 1ns/1ns

module writeback_stage (
    input  logic        clk,
    input  logic        reset,
    input  logic        res_valid,
    input  logic [4:0]  res_rd,
    input  logic [31:0] res_data,
    fwd_if.wb           fwd
);

    always_ff @(posedge clk) begin
        if (reset) begin
            fwd.m_valid <= 1'b0;
            fwd.w_valid <= 1'b0;
        end else begin
            fwd.m_valid <= res_valid;
            fwd.w_valid <= fwd.m_valid;
        end
    end

    // m is the retiring result, w trails it by a cycle
    always_ff @(posedge clk) begin
        fwd.m_rd   <= res_rd;
        fwd.m_data <= res_data;
        fwd.w_rd   <= fwd.m_rd;
        fwd.w_data <= fwd.m_data;
    end

    a_no_x0_write: assert property (@(posedge clk) disable iff (reset)
        fwd.m_valid |-> (fwd.m_rd != 5'd0));

endmodule

// ==== logic/rv_core_top.sv ====
`timescale 1ns/1ns

module rv_core_top #(
    parameter int num_regs = 32
) (
    input  logic        clk,
    input  logic        reset,
    input  logic        in_valid,
    input  logic [31:0] in_instr,
    input  logic [31:0] in_pc,
    output logic        take_branch,
    output logic [31:0] branch_target,
    output logic        wb_valid,
    output logic [4:0]  wb_rd,
    output logic [31:0] wb_data
);

    logic        res_valid;
    logic [4:0]  res_rd;
    logic [31:0] res_data;

    dec_ex_if de_bus ();
    fwd_if    fwd_bus ();

    decode_stage #(
        .num_regs (num_regs)
    ) u_decode (
        .clk         (clk),
        .reset       (reset),
        .in_valid    (in_valid),
        .in_instr    (in_instr),
        .in_pc       (in_pc),
        .take_branch (take_branch),
        .fwd         (fwd_bus.dec),
        .de          (de_bus.dec)
    );

    execute u_execute (
        .clk           (clk),
        .de            (de_bus.ex),
        .fwd           (fwd_bus.ex),
        .res_valid     (res_valid),
        .res_rd        (res_rd),
        .res_data      (res_data),
        .take_branch   (take_branch),
        .branch_target (branch_target)
    );

    writeback_stage u_writeback (
        .clk       (clk),
        .reset     (reset),
        .res_valid (res_valid),
        .res_rd    (res_rd),
        .res_data  (res_data),
        .fwd       (fwd_bus.wb)
    );

    assign wb_valid = fwd_bus.m_valid;
    assign wb_rd    = fwd_bus.m_rd;
    assign wb_data  = fwd_bus.m_data;

endmodule

// ==== bench/rv_core_tb.sv ====
`timescale 1ns/1ns

module rv_core_tb;

    localparam int drain_cycles = 4;

    logic        clk;
    logic        reset;
    logic        in_valid;
    logic [31:0] in_instr;
    logic [31:0] in_pc;
    logic        take_branch;
    logic [31:0] branch_target;
    logic        wb_valid;
    logic [4:0]  wb_rd;
    logic [31:0] wb_data;

    // program events in file order
    logic [7:0]  ev_kind [$];
    logic [31:0] ev_a [$];
    logic [31:0] ev_b [$];

    // expected records, each tagged with its test number
    logic [4:0]  exp_w_rd [$];
    logic [31:0] exp_w_data [$];
    int          exp_w_test [$];
    logic [31:0] exp_r_target [$];
    int          exp_r_test [$];

    int   n_instr;
    int   idle_total;
    int   n_tests;
    int   cur_test;
    int   checks;
    int   errors;
    int   test_checks;
    int   test_errors;
    int   cycles;
    int   limit;
    logic armed;
    logic stim_loaded;

    rv_core_top #(
        .num_regs (32)
    ) rv_core_top_i (
        .clk           (clk),
        .reset         (reset),
        .in_valid      (in_valid),
        .in_instr      (in_instr),
        .in_pc         (in_pc),
        .take_branch   (take_branch),
        .branch_target (branch_target),
        .wb_valid      (wb_valid),
        .wb_rd         (wb_rd),
        .wb_data       (wb_data)
    );

    always #2 clk = ~clk;

    task automatic note_error();
        errors++;
        test_errors++;
    endtask

    task automatic load_stimulus();
        int          fd;
        int          c;
        int          tag_test;
        logic [7:0]  tag;
        logic [31:0] a;
        logic [31:0] b;
        fd = $fopen("bench/core_stimulus.txt", "r");
        if (fd == 0) begin
            $display("could not open bench/core_stimulus.txt");
        end else begin
            tag_test = 0;
            while ($fscanf(fd, " %c", tag) == 1) begin
                a = 32'd0;
                b = 32'd0;
                if (tag == "#") begin
                    c = $fgetc(fd);
                    while (c != 10 && c != -1) begin
                        c = $fgetc(fd);
                    end
                end else if (tag == "I" || tag == "W") begin
                    c = $fscanf(fd, " %h %h", a, b);
                end else begin
                    c = $fscanf(fd, " %h", a);
                end
                case (tag)
                    "T": begin
                        tag_test = a;
                        n_tests++;
                    end
                    "I": n_instr++;
                    "G": idle_total += a;
                    "W": begin
                        exp_w_rd.push_back(a[4:0]);
                        exp_w_data.push_back(b);
                        exp_w_test.push_back(tag_test);
                    end
                    "R": begin
                        exp_r_target.push_back(a);
                        exp_r_test.push_back(tag_test);
                    end
                    "#": ;
                    default: begin
                        $display("stimulus file holds an unknown record type");
                        note_error();
                    end
                endcase
                if (tag == "T" || tag == "I" || tag == "G") begin
                    ev_kind.push_back(tag);
                    ev_a.push_back(a);
                    ev_b.push_back(b);
                end
            end
            $fclose(fd);
            stim_loaded = 1'b1;
        end
    endtask

    task automatic drive_instr(input logic [31:0] pc, input logic [31:0] instr);
        @(posedge clk);
        #1;
        in_valid = 1'b1;
        in_instr = instr;
        in_pc    = pc;
    endtask

    task automatic drive_idle(input int n);
        repeat (n) begin
            @(posedge clk);
            #1;
            in_valid = 1'b0;
        end
    endtask

    task automatic check_writeback();
        if (exp_w_test.size() == 0 || exp_w_test[0] != cur_test) begin
            $display("test %0d: writeback to x%0d that no record expects", cur_test, wb_rd);
            note_error();
        end else begin
            checks++;
            test_checks++;
            if (wb_rd !== exp_w_rd[0]) begin
                $display("[ERROR] wb_rd expected %h got %h", exp_w_rd[0], wb_rd);
                note_error();
            end
            if (wb_data !== exp_w_data[0]) begin
                $display("[ERROR] wb_data expected %h got %h", exp_w_data[0], wb_data);
                note_error();
            end
            void'(exp_w_rd.pop_front());
            void'(exp_w_data.pop_front());
            void'(exp_w_test.pop_front());
        end
    endtask

    task automatic check_redirect();
        if (exp_r_test.size() == 0 || exp_r_test[0] != cur_test) begin
            $display("test %0d: redirect to %h that no record expects", cur_test, branch_target);
            note_error();
        end else begin
            checks++;
            test_checks++;
            if (branch_target !== exp_r_target[0]) begin
                $display("[ERROR] branch_target expected %h got %h", exp_r_target[0],
                         branch_target);
                note_error();
            end
            void'(exp_r_target.pop_front());
            void'(exp_r_test.pop_front());
        end
    endtask

    // outputs settle well before the falling edge
    always @(negedge clk) begin
        if (!reset) begin
            if (wb_valid !== 1'b0) begin
                check_writeback();
            end
            if (take_branch !== 1'b0) begin
                check_redirect();
            end
        end
    end

    task automatic finish_test();
        drive_idle(drain_cycles);
        while (exp_w_test.size() > 0 && exp_w_test[0] == cur_test) begin
            $display("test %0d: expected writeback to x%0d never came", cur_test, exp_w_rd[0]);
            note_error();
            void'(exp_w_rd.pop_front());
            void'(exp_w_data.pop_front());
            void'(exp_w_test.pop_front());
        end
        while (exp_r_test.size() > 0 && exp_r_test[0] == cur_test) begin
            $display("test %0d: expected redirect to %h never came", cur_test, exp_r_target[0]);
            note_error();
            void'(exp_r_target.pop_front());
            void'(exp_r_test.pop_front());
        end
        $display("test %0d: %s, %0d checks, %0d errors", cur_test,
                 (test_errors == 0) ? "ok" : "failed", test_checks, test_errors);
    endtask

    task automatic run_events();
        foreach (ev_kind[i]) begin
            if (ev_kind[i] == "T") begin
                if (cur_test != 0) begin
                    finish_test();
                end
                cur_test    = ev_a[i];
                test_checks = 0;
                test_errors = 0;
            end else if (ev_kind[i] == "I") begin
                drive_instr(ev_a[i], ev_b[i]);
            end else begin
                drive_idle(ev_a[i]);
            end
        end
        if (cur_test != 0) begin
            finish_test();
        end
    endtask

    // every event takes one cycle, plus the drain after each test
    always @(posedge clk) begin
        if (armed) begin
            cycles = cycles + 1;
            if (cycles > limit) begin
                $display("timeout after %0d cycles, the run did not finish", cycles);
                $display("Checks failed");
                $finish;
            end
        end
    end

    initial begin
        clk         = 1'b0;
        reset       = 1'b1;
        in_valid    = 1'b0;
        in_instr    = 32'd0;
        in_pc       = 32'd0;
        n_instr     = 0;
        idle_total  = 0;
        n_tests     = 0;
        cur_test    = 0;
        checks      = 0;
        errors      = 0;
        test_checks = 0;
        test_errors = 0;
        cycles      = 0;
        armed       = 1'b0;
        stim_loaded = 1'b0;
        load_stimulus();
        limit = n_instr + idle_total + n_tests * drain_cycles + 20;
        repeat (5) @(posedge clk);
        #1;
        reset = 1'b0;
        armed = 1'b1;
        if (stim_loaded) begin
            run_events();
        end
        $display("%0d tests, %0d checks, %0d errors", n_tests, checks, errors);
        if (stim_loaded && errors == 0) begin
            $display("All checks passed");
        end else begin
            $display("Checks failed");
        end
        $finish;
    end

endmodule

// ==== bench/core_stimulus.txt ====
# fields in hex: I pc instr | G idle_cycles | W rd data | R target | T test
# W and R lines are the expected writebacks and redirects of the test above them
T 1
G 8
# alu ops, lui, auipc, write to x0
T 2
I 00000100 fff00093
I 00000104 00500113
I 00000108 800001b7
I 0000010c 12345217
I 00000110 401102b3
I 00000114 0020a333
I 00000118 0020b3b3
I 0000011c 4041d413
I 00000120 0ff14513
I 00000124 01f11593
I 00000128 0011f633
I 0000012c 00710013
I 00000130 ff016693
W 01 ffffffff
W 02 00000005
W 03 80000000
W 04 1234510c
W 05 00000006
W 06 00000001
W 07 00000000
W 08 f8000000
W 0a 000000fa
W 0b 80000000
W 0c 80000000
W 0d fffffff5
# dependent chains over one-ahead, two-ahead and register file
T 3
I 00000200 00a00813
I 00000204 00180893
I 00000208 01180933
I 0000020c 410909b3
G 1
I 00000210 01298a33
G 2
I 00000214 010a4ab3
I 00000218 000a8813
I 0000021c 01080b33
I 00000220 00580013
I 00000224 01600bb3
W 10 0000000a
W 11 0000000b
W 12 00000015
W 13 0000000b
W 14 00000020
W 15 0000002a
W 10 0000002a
W 16 00000054
W 17 00000054
# branches, the slot after a taken one tries to write x24
T 4
I 00000300 00210863
I 00000304 7ff00c13
I 00000310 00211863
I 00000314 00100c93
I 00000318 fe20cce3
I 0000031c 7ff00c13
I 00000310 0020e863
I 00000314 0020f863
I 00000318 7ff00c13
I 00000324 0011d863
I 00000328 0030d863
I 0000032c 7ff00c13
I 00000338 00500d13
I 0000033c 002d0863
I 00000340 7ff00c13
W 19 00000001
W 1a 00000005
R 00000310
R 00000310
R 00000324
R 00000338
R 0000034c
# jal and jalr
T 5
I 00000400 020002ef
I 00000404 7ff00c13
I 00000420 10128367
I 00000424 7ff00c13
I 00000504 f01ff06f
I 00000508 7ff00c13
I 00000404 123003e7
I 00000408 7ff00c13
W 05 00000404
W 06 00000424
W 07 00000408
R 00000420
R 00000504
R 00000404
R 00000122
# load, store and fence do nothing
T 6
I 00000500 00012403
I 00000504 00202223
I 00000508 0000000f
I 0000050c 00040d93
W 1b f8000000

// ==== files.f ====
logic/rv_pkg.sv
logic/pipe_if.sv
logic/reg_file.sv
logic/decode_stage.sv
logic/alu.sv
logic/execute.sv
logic/writeback_stage.sv
logic/rv_core_top.sv
bench/rv_core_tb.sv

// ==== Makefile ====
VERILATOR ?= verilator
VFLAGS    ?= --binary --timing --assert -j 0
TOP       ?= rv_core_tb
FILELIST  ?= files.f
LOG       ?= sim.log

.PHONY: simulate clean

simulate:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST)
	./obj_dir/V$(TOP) 2>&1 | tee $(LOG)
	! grep -q "Checks failed" $(LOG)
	grep -q "All checks passed" $(LOG)

clean:
	rm -rf obj_dir $(LOG)
